// ==== rtl/cam_fb_pkg.sv ====
`default_nettype none

package cam_fb_pkg;

	// ----------------------------------------------------------
	// Sizes
	// ----------------------------------------------------------
	localparam int FB_DATA_W      = 32;  // Buffer and bus word
	localparam int CAM_BYTE_W     = 8;   // One camera byte
	localparam int BYTES_PER_WORD = 4;

	localparam int BANK_DEPTH     = 512; // Words per bank
	localparam int BANK_ADR_W     = 9;
	localparam int NUM_BANKS      = 4;
	localparam int BANK_SEL_W     = 2;

	// Top BANK_SEL_W bits pick the bank
	localparam int FB_ADR_W       = 11;

	// Host address, only low BANK_ADR_W bits reach a bank
	localparam int WB_ADR_W       = 11;

	// Status word layout, unlisted bits read zero
	localparam int STAT_BANK_LSB  = 0;   // Bank now being filled
	localparam int STAT_VSYNC_BIT = 8;   // Live VSYNC level

	// ----------------------------------------------------------
	// Types
	// ----------------------------------------------------------
	typedef logic [FB_DATA_W-1:0]  fb_word_t;
	typedef logic [FB_ADR_W-1:0]   fb_adr_t;
	typedef logic [BANK_SEL_W-1:0] bank_sel_t;

	// Camera pins, sampled on the bus clock
	typedef struct packed {
		logic                  vsync;
		logic                  href;
		logic [CAM_BYTE_W-1:0] data;
	} cam_in_t;

	// Host request side of the slave port
	typedef struct packed {
		logic [WB_ADR_W-1:0]  adr;
		logic [NUM_BANKS-1:0] bank_cyc;   // One strobe per bank
		logic                 status_cyc; // Status word select
		logic                 stb;
	} wb_req_t;

endpackage

`default_nettype wire

// ==== rtl/cam_pixel_packer.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_pixel_packer import cam_fb_pkg::*; (
	input  wire logic     WBs_CLK_i,
	input  wire logic     WBs_RST_i,
	input  wire cam_in_t  cam_i,     // Camera levels and data byte
	output logic          push_o,    // One cycle per finished word
	output fb_word_t      word_o     // Valid while push_o is high
);

	// ----------------------------------------------------------
	// Byte qualification
	// ----------------------------------------------------------
	logic                                 byte_vld;
	logic [$clog2(BYTES_PER_WORD)-1:0]    phase_q;   // Bytes already held
	logic [FB_DATA_W-CAM_BYTE_W-1:0]      acc_q;     // First three bytes
	logic                                 last_byte;
	logic                                 push_q;
	fb_word_t                             word_q;

	// Byte counts only inside an active line of an active frame
	assign byte_vld  = cam_i.href & cam_i.vsync;
	assign last_byte = (phase_q == BYTES_PER_WORD - 1);

	// ----------------------------------------------------------
	// Byte phase FSM
	// ----------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			phase_q <= '0;
			push_q  <= 1'b0;
		end else begin
			push_q <= 1'b0; // Default, push is a pulse
			if (byte_vld) begin
				if (last_byte) begin
					phase_q <= '0;   // Word complete, start over
					push_q  <= 1'b1;
				end else begin
					phase_q <= phase_q + 1'b1;
				end
			end
			// Gap keeps the phase, a word may span gaps
		end
	end

	// ----------------------------------------------------------
	// Accumulator and word register
	// ----------------------------------------------------------
	// Earlier bytes move up, newest byte enters at the bottom
	always_ff @(posedge WBs_CLK_i) begin
		if (byte_vld) begin
			if (last_byte) begin
				word_q <= {acc_q, cam_i.data}; // First byte ends in MSB
			end else begin
				acc_q <= {acc_q[FB_DATA_W-2*CAM_BYTE_W-1:0], cam_i.data};
			end
		end
	end

	assign push_o = push_q;
	assign word_o = word_q;

	// A new word needs four sampled bytes, so pushes never touch
	a_push_single : assert property (
		@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		push_o |=> !push_o
	);

endmodule

`default_nettype wire

// ==== rtl/cam_frame_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_frame_buffer import cam_fb_pkg::*; (
	input  wire logic                  WBs_CLK_i,
	input  wire logic                  WBs_RST_i,
	input  wire logic                  push_i,    // Write word_i, then step address
	input  wire fb_word_t              word_i,
	input  wire logic [BANK_ADR_W-1:0] rd_adr_i,  // Word inside the bank
	input  wire bank_sel_t             rd_bank_i,
	output bank_sel_t                  wr_bank_o, // Bank now being filled
	output fb_word_t                   rd_word_o  // One cycle after rd_adr_i
);

	// ----------------------------------------------------------
	// Write address
	// ----------------------------------------------------------
	fb_adr_t                  wr_adr_q;
	bank_sel_t                wr_bank;
	logic [BANK_ADR_W-1:0]    wr_row;
	logic [NUM_BANKS-1:0]     bank_we;   // One-hot while pushing
	fb_word_t [NUM_BANKS-1:0] bank_rd_q; // Registered read of every bank
	bank_sel_t                rd_bank_q;

	// Plain binary count, 2047 rolls over to 0
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			wr_adr_q <= '0;
		end else if (push_i) begin
			wr_adr_q <= wr_adr_q + 1'b1;
		end
	end

	assign wr_bank = wr_adr_q[FB_ADR_W-1 -: BANK_SEL_W]; // Top bits
	assign wr_row  = wr_adr_q[BANK_ADR_W-1:0];
	assign wr_bank_o = wr_bank;

	// Bank write enable decode
	always_comb begin
		bank_we = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (push_i && (wr_bank == bank_sel_t'(b))) begin
				bank_we[b] = 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// Bank arrays
	// ----------------------------------------------------------
	// Simple dual port, one write port, one synchronous read port
	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		fb_word_t mem [BANK_DEPTH];

		always_ff @(posedge WBs_CLK_i) begin
			if (bank_we[b]) begin
				mem[wr_row] <= word_i;
			end
			bank_rd_q[b] <= mem[rd_adr_i]; // Read before write on a clash
		end
	end

	// ----------------------------------------------------------
	// Read select
	// ----------------------------------------------------------
	// Bank choice sampled on the same edge as the array reads
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			rd_bank_q <= '0;
		end else begin
			rd_bank_q <= rd_bank_i;
		end
	end

	assign rd_word_o = bank_rd_q[rd_bank_q];

	// Address only moves on the cycle after a push
	a_adr_on_push : assert property (
		@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		$changed(wr_adr_q) |-> $past(push_i)
	);

endmodule

`default_nettype wire

// ==== rtl/wb_fb_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_fb_slave import cam_fb_pkg::*; (
	input  wire logic             WBs_CLK_i,
	input  wire logic             WBs_RST_i,
	input  wire wb_req_t          wb_req_i,
	input  wire fb_word_t         rd_word_i,  // Registered bank word
	input  wire bank_sel_t        wr_bank_i,  // Bank being filled
	input  wire logic             vsync_i,
	output logic [BANK_ADR_W-1:0] rd_adr_o,
	output bank_sel_t             rd_bank_o,
	output logic                  wb_ack_o,
	output fb_word_t              wb_dat_o
);

	// ----------------------------------------------------------
	// Cycle decode
	// ----------------------------------------------------------
	logic     cyc_any;
	logic     cyc_open;     // Open cycle not yet acked
	logic     ack_q;
	logic     sel_status_q; // Acked cycle was a status read
	fb_word_t status_word;
	fb_word_t status_q;
	fb_word_t live_word;
	fb_word_t dat_q;        // Data of the last ack

	assign cyc_any  = (|wb_req_i.bank_cyc) | wb_req_i.status_cyc;
	assign cyc_open = wb_req_i.stb & cyc_any & ~ack_q;

	// One-hot bank strobe to bank index
	always_comb begin
		rd_bank_o = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (wb_req_i.bank_cyc[b]) begin
				rd_bank_o = bank_sel_t'(b);
			end
		end
	end

	assign rd_adr_o = wb_req_i.adr[BANK_ADR_W-1:0]; // Word inside bank

	// Status layout from the package
	always_comb begin
		status_word = '0;
		status_word[STAT_BANK_LSB +: BANK_SEL_W] = wr_bank_i;
		status_word[STAT_VSYNC_BIT] = vsync_i;
	end

	// ----------------------------------------------------------
	// Acknowledge
	// ----------------------------------------------------------
	// Writes get the same single ack and touch nothing
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			ack_q        <= 1'b0;
			sel_status_q <= 1'b0;
		end else begin
			ack_q <= cyc_open;
			if (cyc_open) begin
				sel_status_q <= wb_req_i.status_cyc;
			end
		end
	end

	// Status snapshot taken on the ack edge
	always_ff @(posedge WBs_CLK_i) begin
		if (cyc_open) begin
			status_q <= status_word;
		end
	end

	// ----------------------------------------------------------
	// Read data
	// ----------------------------------------------------------
	// Bank word arrives with ack, host may drop the address mid ack
	assign live_word = sel_status_q ? status_q : rd_word_i;

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			dat_q <= '0;
		end else if (ack_q) begin
			dat_q <= live_word; // Kept until the next ack
		end
	end

	assign wb_ack_o = ack_q;
	assign wb_dat_o = ack_q ? live_word : dat_q;

	// Host selects one target per strobe
	a_one_cyc : assert property (
		@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		wb_req_i.stb |-> $onehot0({wb_req_i.bank_cyc, wb_req_i.status_cyc})
	);

endmodule

`default_nettype wire

// ==== rtl/cam_fb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_fb_top import cam_fb_pkg::*; (
	input  wire logic    WBs_CLK_i,
	input  wire logic    WBs_RST_i,
	input  wire cam_in_t cam_i,    // Camera stream on the bus clock
	input  wire wb_req_t wb_req_i, // Host request
	output logic         wb_ack_o,
	output fb_word_t     wb_dat_o
);

	// ----------------------------------------------------------
	// Internal nets
	// ----------------------------------------------------------
	logic                  push;    // Packer word strobe
	fb_word_t              word;
	bank_sel_t             wr_bank;
	fb_word_t              rd_word;
	logic [BANK_ADR_W-1:0] rd_adr;
	bank_sel_t             rd_bank;

	// Camera bytes to words
	cam_pixel_packer u_packer (
		.WBs_CLK_i (WBs_CLK_i),
		.WBs_RST_i (WBs_RST_i),
		.cam_i     (cam_i),
		.push_o    (push),
		.word_o    (word)
	);

	// Four banks, filled in order
	cam_frame_buffer u_frame_buf (
		.WBs_CLK_i (WBs_CLK_i),
		.WBs_RST_i (WBs_RST_i),
		.push_i    (push),
		.word_i    (word),
		.rd_adr_i  (rd_adr),
		.rd_bank_i (rd_bank),
		.wr_bank_o (wr_bank),
		.rd_word_o (rd_word)
	);

	// Host side
	wb_fb_slave u_slave (
		.WBs_CLK_i (WBs_CLK_i),
		.WBs_RST_i (WBs_RST_i),
		.wb_req_i  (wb_req_i),
		.rd_word_i (rd_word),
		.wr_bank_i (wr_bank),
		.vsync_i   (cam_i.vsync), // Shown in status bit
		.rd_adr_o  (rd_adr),
		.rd_bank_o (rd_bank),
		.wb_ack_o  (wb_ack_o),
		.wb_dat_o  (wb_dat_o)
	);

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic rst_o
);

	localparam int CLK_PERIOD = 100; // ns
	localparam int RST_CYCLES = 5;

	// Free-running bus clock
	initial begin
		clk_o = 1'b0;
		forever #(CLK_PERIOD / 2) clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		@(negedge clk_o); // Release away from the active edge
		rst_o = 1'b0;
	end

endmodule

`default_nettype wire

// ==== verif/cam_fb_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cam_fb_tb import cam_fb_pkg::*; ();

	// ----------------------------------------------------------
	// Run limits
	// ----------------------------------------------------------
	// About 2100 words at 8 cycles each plus the reads, doubled
	localparam int          TIMEOUT_CYCLES = 40000;
	localparam int          ACK_WAIT_MAX   = 16;
	localparam int unsigned RAND_SEED      = 32'h67a8_b653;
	localparam int          FB_WORDS       = NUM_BANKS * BANK_DEPTH;

	// One pending bus cycle, queued by stimulus, consumed on ack
	typedef struct packed {
		logic                  has_data;  // Clear for write cycles
		logic                  is_status;
		bank_sel_t             bank;
		logic [BANK_ADR_W-1:0] adr;
		fb_word_t              data;      // Expected wb_dat_o
	} exp_t;

	logic     WBs_CLK_i;
	logic     WBs_RST_i;
	cam_in_t  cam_i;
	wb_req_t  wb_req_i;
	logic     wb_ack_o;
	fb_word_t wb_dat_o;

	logic [CAM_BYTE_W-1:0] sent_bytes[$]; // Every valid byte, in order
	exp_t                  exp_q[$];
	exp_t                  cur_exp;
	int unsigned           words_sent;
	int                    err_cnt;
	int                    chk_cnt;
	int                    cycle_cnt;

	tb_clk_gen u_clk_gen (
		.clk_o (WBs_CLK_i),
		.rst_o (WBs_RST_i)
	);

	cam_fb_top cam_fb_top_inst (
		.WBs_CLK_i (WBs_CLK_i),
		.WBs_RST_i (WBs_RST_i),
		.cam_i     (cam_i),
		.wb_req_i  (wb_req_i),
		.wb_ack_o  (wb_ack_o),
		.wb_dat_o  (wb_dat_o)
	);

	// ----------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------
	// Word idx from bytes 4idx..4idx+3, first byte on top
	function automatic fb_word_t expect_word(input int unsigned idx, output bank_sel_t bank);
		fb_word_t    w;
		int unsigned base;
		w    = '0;
		base = idx * BYTES_PER_WORD;
		if (base + BYTES_PER_WORD <= sent_bytes.size()) begin
			for (int i = 0; i < BYTES_PER_WORD; i++) begin
				w = {w[FB_DATA_W-CAM_BYTE_W-1:0], sent_bytes[base + i]};
			end
		end
		bank = bank_sel_t'((idx % FB_WORDS) / BANK_DEPTH); // Address bits 10:9
		return w;
	endfunction

	// ----------------------------------------------------------
	// Camera stimulus
	// ----------------------------------------------------------
	task automatic stream_words(input int unsigned n_words);
		int unsigned gap_len;
		int unsigned gap_kind;
		logic [CAM_BYTE_W-1:0] b;
		for (int unsigned i = 0; i < n_words * BYTES_PER_WORD; i++) begin
			gap_len = (($urandom % 4) == 0) ? (($urandom % 3) + 1) : 0;
			for (int unsigned g = 0; g < gap_len; g++) begin
				@(negedge WBs_CLK_i);
				gap_kind   = $urandom % 3;
				cam_i.data = 8'($urandom);        // Junk, must be ignored
				cam_i.href  = (gap_kind == 1);    // Kind 1 drops only vsync
				cam_i.vsync = (gap_kind == 0);    // Kind 0 drops only href
			end
			b = 8'($urandom);
			@(negedge WBs_CLK_i);
			cam_i.vsync = 1'b1;
			cam_i.href  = 1'b1;
			cam_i.data  = b;
			sent_bytes.push_back(b);
		end
		@(negedge WBs_CLK_i);
		cam_i.href  = 1'b0; // Line idle, frame stays active
		cam_i.vsync = 1'b1;
		words_sent += n_words;
	endtask

	task automatic set_vsync(input logic level);
		@(negedge WBs_CLK_i);
		cam_i.href  = 1'b0; // No bytes while toggling
		cam_i.vsync = level;
	endtask

	// ----------------------------------------------------------
	// Bus stimulus
	// ----------------------------------------------------------
	task automatic bus_cycle(input logic is_status, input bank_sel_t bank,
		input logic [BANK_ADR_W-1:0] adr, input logic has_data, input fb_word_t exp_val);
		exp_t e;
		int   wait_cnt;
		e.has_data  = has_data;
		e.is_status = is_status;
		e.bank      = bank;
		e.adr       = adr;
		e.data      = exp_val;
		@(negedge WBs_CLK_i);
		exp_q.push_back(e);
		wb_req_i.adr        = WB_ADR_W'(adr);
		wb_req_i.bank_cyc   = '0;
		if (!is_status) begin
			wb_req_i.bank_cyc[bank] = 1'b1;
		end
		wb_req_i.status_cyc = is_status;
		wb_req_i.stb        = 1'b1;
		@(negedge WBs_CLK_i);
		wait_cnt = 1;
		while (wb_ack_o !== 1'b1 && wait_cnt < ACK_WAIT_MAX) begin
			@(negedge WBs_CLK_i);
			wait_cnt++;
		end
		if (wb_ack_o !== 1'b1) begin
			$display("No acknowledge within %0d cycles at %0t", ACK_WAIT_MAX, $time);
			err_cnt++;
		end else if (wait_cnt != 1) begin
			$display("Acknowledge came %0d cycles after the strobe, expected 1", wait_cnt);
			err_cnt++;
		end
		wb_req_i = '0; // Host drops the strobe once ack is seen
		@(negedge WBs_CLK_i);
		if (wb_ack_o !== 1'b0) begin
			$display("[FAIL] wb_ack_o expected %h got %h", 1'b0, wb_ack_o);
			err_cnt++;
		end
		// Read data stays on the bus after ack
		if (has_data && wb_dat_o !== exp_val) begin
			$display("[FAIL] wb_dat_o after ack expected %h got %h", exp_val, wb_dat_o);
			err_cnt++;
		end
	endtask

	task automatic read_word(input int unsigned idx);
		bank_sel_t bank;
		fb_word_t  w;
		w = expect_word(idx, bank);
		bus_cycle(1'b0, bank, BANK_ADR_W'(idx % BANK_DEPTH), 1'b1, w);
	endtask

	task automatic read_status();
		bank_sel_t bank;
		fb_word_t  w;
		void'(expect_word(words_sent, bank)); // Bank now being filled
		w = '0;
		w[STAT_BANK_LSB +: BANK_SEL_W] = bank;
		w[STAT_VSYNC_BIT]              = cam_i.vsync;
		bus_cycle(1'b1, '0, '0, 1'b1, w);
	endtask

	// Host write, acked but ignored
	task automatic write_cycle(input logic is_status, input bank_sel_t bank,
		input logic [BANK_ADR_W-1:0] adr);
		bus_cycle(is_status, bank, adr, 1'b0, '0);
	endtask

	task automatic print_summary();
		$display("Summary: %0d data checks, %0d errors, %0d cycles", chk_cnt, err_cnt,
			cycle_cnt);
	endtask

	// ----------------------------------------------------------
	// Read data comparison
	// ----------------------------------------------------------
	// Outputs are registered, so the falling edge sees them settled
	always @(negedge WBs_CLK_i) begin
		if (wb_ack_o === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("Acknowledge seen with no bus cycle pending at %0t", $time);
				err_cnt++;
			end else begin
				cur_exp = exp_q.pop_front();
				if (cur_exp.has_data) begin
					chk_cnt++;
					if (wb_dat_o !== cur_exp.data) begin
						$display("[FAIL] wb_dat_o expected %h got %h (status %0d bank %0d adr %h)",
							cur_exp.data, wb_dat_o, cur_exp.is_status, cur_exp.bank,
							cur_exp.adr);
						err_cnt++;
					end
				end
			end
		end
	end

	// Watchdog
	always @(posedge WBs_CLK_i) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout, run stopped after %0d cycles", cycle_cnt);
			print_summary();
			$display("Errors found");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------
	initial begin
		cam_i      = '0;
		wb_req_i   = '0;
		words_sent = 0;
		err_cnt    = 0;
		chk_cnt    = 0;
		cycle_cnt  = 0;
		void'($urandom(RAND_SEED)); // Only seeding point of the run

		@(negedge WBs_RST_i);
		@(negedge WBs_CLK_i);
		if (wb_ack_o !== 1'b0) begin
			$display("[FAIL] wb_ack_o expected %h got %h", 1'b0, wb_ack_o);
			err_cnt++;
		end
		if (wb_dat_o !== '0) begin
			$display("[FAIL] wb_dat_o expected %h got %h", 32'h0, wb_dat_o);
			err_cnt++;
		end
		read_status(); // Bank 0, vsync low

		// VSYNC toggles with href low, nothing pushed
		set_vsync(1'b1);
		read_status();
		set_vsync(1'b0);
		read_status();
		set_vsync(1'b1);
		read_status();
		write_cycle(1'b1, '0, '0);
		read_status();

		// Packing with gaps inside and between words
		stream_words(100);
		for (int unsigned k = 0; k < 100; k++) begin
			read_word(k);
		end
		write_cycle(1'b0, 2'd0, 9'd7);
		read_word(7);     // Untouched by the write
		write_cycle(1'b0, 2'd0, 9'd99);
		read_word(99);
		read_status();

		// Into bank 1
		stream_words(500);
		read_status();
		read_word(511);
		read_word(512);   // Bank 1 address 0
		read_word(513);
		read_word(599);

		// Past the end, address wraps into bank 0
		stream_words(1450);
		read_status();
		read_word(2048);  // Overwrote bank 0 address 0
		read_word(2049);
		read_word(2047);  // Last word of bank 3
		read_word(1024);
		read_word(1536);
		read_word(600);
		write_cycle(1'b0, 2'd3, 9'd511);
		read_word(2047);

		if (exp_q.size() != 0) begin
			$display("%0d bus cycles were never acknowledged", exp_q.size());
			err_cnt++;
		end
		print_summary();
		if (err_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/cam_fb_pkg.sv
rtl/cam_pixel_packer.sv
rtl/cam_frame_buffer.sv
rtl/wb_fb_slave.sv
rtl/cam_fb_top.sv
verif/tb_clk_gen.sv
verif/cam_fb_tb.sv

// ==== Bender.yml ====
package:
  name: cam_fb

sources:
  - rtl/cam_fb_pkg.sv
  - rtl/cam_pixel_packer.sv
  - rtl/cam_frame_buffer.sv
  - rtl/wb_fb_slave.sv
  - rtl/cam_fb_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/cam_fb_tb.sv
